// ==== verilog/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and register file
`define CORE_XLEN 32
`define CORE_REG_COUNT 32
`define CORE_RADDR_W 5

// fetch
`define CORE_RESET_PC 32'h0000_0000
`define CORE_INSTR_BYTES 4

// word address width of data ram
`define CORE_RAM_AW 10

`endif

// ==== verilog/core_pkg.sv ====
`default_nettype none
`include "core_params.svh"

package core_pkg;

   typedef logic [`CORE_XLEN-1:0] word_t;
   typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

   // major opcodes, rv32i subset
   typedef enum logic [6:0] {
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_jal    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt
   } alu_op_e;

   // top bit is the prediction
   typedef enum logic [1:0] {
      bp_strong_nt = 2'b00,
      bp_weak_nt   = 2'b01,
      bp_weak_t    = 2'b10,
      bp_strong_t  = 2'b11
   } bp_state_e;

   typedef enum logic [1:0] {
      fwd_rf  = 2'd0,
      fwd_mem = 2'd1,
      fwd_wb  = 2'd2
   } fwd_sel_e;

   typedef struct packed {
      word_t     pc;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      word_t     imm;
      alu_op_e   alu_op;
      logic      uses_rs1;
      logic      uses_rs2;
      logic      writes_rd;
      logic      is_load;
      logic      is_store;
      logic      is_branch;
      logic      branch_on_ne;
      logic      is_jal;
      logic      uses_imm;
   } decoded_t;

endpackage

`default_nettype wire

// ==== verilog/bypass_if.sv ====
`default_nettype none

interface bypass_if (
   input wire clk
);
   import core_pkg::*;

   // instruction that has just left execute
   logic      ex_valid;
   reg_addr_t ex_rd;
   logic      ex_writes;
   logic      ex_is_load;
   word_t     mem_result;

   // instruction in write-back
   logic      wb_valid;
   reg_addr_t wb_rd;
   logic      wb_writes;
   word_t     wb_result;

   modport pipe (
      output ex_valid, ex_rd, ex_writes, ex_is_load, mem_result,
      output wb_valid, wb_rd, wb_writes, wb_result
   );

   modport hazard (
      input clk,
      input ex_valid, ex_rd, ex_writes, ex_is_load,
      input wb_valid, wb_rd, wb_writes
   );

endinterface

`default_nettype wire

// ==== verilog/decoder.sv ====
`default_nettype none

module decoder (
   input  wire core_pkg::word_t    instr_raw,
   input  wire core_pkg::word_t    pc,
   output core_pkg::decoded_t dec
);
   import core_pkg::*;

   opcode_e    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_j;
   logic       rd_nz;
   logic       legal;

   assign opcode = opcode_e'(instr_raw[6:0]);
   assign funct3 = instr_raw[14:12];
   assign funct7 = instr_raw[31:25];
   assign rd_nz  = (instr_raw[11:7] != '0);

   // sign-extended immediates
   assign imm_i = {{20{instr_raw[31]}}, instr_raw[31:20]};
   assign imm_s = {{20{instr_raw[31]}}, instr_raw[31:25], instr_raw[11:7]};
   assign imm_b = {{19{instr_raw[31]}}, instr_raw[31], instr_raw[7],
                   instr_raw[30:25], instr_raw[11:8], 1'b0};
   assign imm_j = {{11{instr_raw[31]}}, instr_raw[31], instr_raw[19:12],
                   instr_raw[20], instr_raw[30:21], 1'b0};

   always_comb begin
      dec        = '0;
      dec.pc     = pc;
      dec.rs1    = instr_raw[19:15];
      dec.rs2    = instr_raw[24:20];
      dec.rd     = instr_raw[11:7];
      dec.alu_op = alu_add;
      legal      = 1'b1;
      case (opcode)
         opc_op: begin
            dec.uses_rs1  = 1'b1;
            dec.uses_rs2  = 1'b1;
            dec.writes_rd = rd_nz;
            case ({funct7, funct3})
               {7'h00, 3'b000}: dec.alu_op = alu_add;
               {7'h20, 3'b000}: dec.alu_op = alu_sub;
               {7'h00, 3'b111}: dec.alu_op = alu_and;
               {7'h00, 3'b110}: dec.alu_op = alu_or;
               {7'h00, 3'b100}: dec.alu_op = alu_xor;
               {7'h00, 3'b010}: dec.alu_op = alu_slt;
               default:         legal = 1'b0;
            endcase
         end
         opc_op_imm: begin
            dec.uses_rs1  = 1'b1;
            dec.uses_imm  = 1'b1;
            dec.writes_rd = rd_nz;
            dec.imm       = imm_i;
            legal         = (funct3 == 3'b000);
         end
         opc_load: begin
            dec.uses_rs1  = 1'b1;
            dec.uses_imm  = 1'b1;
            dec.is_load   = 1'b1;
            dec.writes_rd = rd_nz;
            dec.imm       = imm_i;
            legal         = (funct3 == 3'b010);
         end
         opc_store: begin
            dec.uses_rs1 = 1'b1;
            dec.uses_rs2 = 1'b1;
            dec.uses_imm = 1'b1;
            dec.is_store = 1'b1;
            dec.imm      = imm_s;
            legal        = (funct3 == 3'b010);
         end
         opc_branch: begin
            dec.uses_rs1     = 1'b1;
            dec.uses_rs2     = 1'b1;
            dec.is_branch    = 1'b1;
            dec.branch_on_ne = funct3[0];
            dec.imm          = imm_b;
            legal            = (funct3[2:1] == 2'b00);
         end
         opc_jal: begin
            dec.is_jal    = 1'b1;
            dec.writes_rd = rd_nz;
            dec.imm       = imm_j;
         end
         default: legal = 1'b0;
      endcase
      // anything else becomes a no-op
      if (!legal) begin
         dec    = '0;
         dec.pc = pc;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none
`include "core_params.svh"

module regfile (
   input  wire                        clk,
   input  wire                        rstn,
   input  wire core_pkg::reg_addr_t   rs1,
   input  wire core_pkg::reg_addr_t   rs2,
   input  wire                        w_enable,
   input  wire core_pkg::reg_addr_t   w_addr,
   input  wire core_pkg::word_t       w_data,
   output core_pkg::word_t            rs1_data,
   output core_pkg::word_t            rs2_data
);
   import core_pkg::*;

   word_t regs [`CORE_REG_COUNT];

   always_ff @(posedge clk) begin
      if (w_enable && w_addr != '0) begin
         regs[w_addr] <= w_data;
      end
   end

   // x0 reads zero, same-cycle write passes through
   assign rs1_data = (rs1 == '0) ? '0 :
                     (w_enable && w_addr == rs1) ? w_data : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 :
                     (w_enable && w_addr == rs2) ? w_data : regs[rs2];

   a_x0_reads_zero: assert property (@(posedge clk) disable iff (rstn)
      (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0));

endmodule

`default_nettype wire

// ==== verilog/alu_exec.sv ====
`default_nettype none
`include "core_params.svh"

module alu_exec (
   input  wire core_pkg::decoded_t dec,
   input  wire core_pkg::word_t    op_a,
   input  wire core_pkg::word_t    op_b,
   output core_pkg::word_t         result,
   output logic                    taken,
   output core_pkg::word_t         target
);
   import core_pkg::*;

   word_t operand_b;
   word_t alu_out;
   logic  less;
   logic  equal;

   // immediate forms replace rs2
   assign operand_b = dec.uses_imm ? dec.imm : op_b;
   assign less      = ($signed(op_a) < $signed(operand_b));

   ////////////////////
   // alu
   ////////////////////
   always_comb begin
      case (dec.alu_op)
         alu_sub: alu_out = op_a - operand_b;
         alu_and: alu_out = op_a & operand_b;
         alu_or:  alu_out = op_a | operand_b;
         alu_xor: alu_out = op_a ^ operand_b;
         alu_slt: alu_out = {{(`CORE_XLEN-1){1'b0}}, less};
         // add, and load/store address
         default: alu_out = op_a + operand_b;
      endcase
   end

   // link value for jal
   assign result = dec.is_jal ? dec.pc + word_t'(`CORE_INSTR_BYTES) : alu_out;

   ////////////////////
   // branch resolve
   ////////////////////
   assign equal  = (op_a == op_b);
   assign taken  = dec.is_jal || (dec.is_branch && (equal != dec.branch_on_ne));
   assign target = dec.pc + dec.imm;

endmodule

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
`default_nettype none
`include "core_params.svh"

module branch_predictor (
   input  wire                      clk,
   input  wire                      rstn,
   input  wire core_pkg::decoded_t  dec_id,
   input  wire                      id_valid,
   input  wire core_pkg::decoded_t  dec_ex,
   input  wire                      ex_valid,
   input  wire                      ex_taken,
   input  wire core_pkg::word_t     ex_target,
   input  wire                      ex_predicted,
   output logic                     redirect_id,
   output core_pkg::word_t          redirect_id_pc,
   output logic                     id_predicted,
   output logic                     mispredict,
   output core_pkg::word_t          recover_pc
);
   import core_pkg::*;

   bp_state_e state;
   logic      resolve;

   assign resolve = ex_valid && dec_ex.is_branch;

   // saturating global counter
   always_ff @(posedge clk) begin
      if (rstn) begin
         state <= bp_strong_nt;
      end else if (resolve) begin
         case (state)
            bp_strong_nt: state <= ex_taken ? bp_weak_nt  : bp_strong_nt;
            bp_weak_nt:   state <= ex_taken ? bp_weak_t   : bp_strong_nt;
            bp_weak_t:    state <= ex_taken ? bp_strong_t : bp_weak_nt;
            default:      state <= ex_taken ? bp_strong_t : bp_weak_t;
         endcase
      end
   end

   // decode side, jal always taken
   assign id_predicted   = dec_id.is_jal || (dec_id.is_branch && state[1]);
   assign redirect_id    = id_valid && id_predicted;
   assign redirect_id_pc = dec_id.pc + dec_id.imm;

   // execute side
   assign mispredict = ex_valid && (dec_ex.is_branch || dec_ex.is_jal) &&
                       (ex_taken != ex_predicted);
   assign recover_pc = ex_taken ? ex_target : dec_ex.pc + word_t'(`CORE_INSTR_BYTES);

   a_counter_only_on_branch: assert property (@(posedge clk) disable iff (rstn)
      !resolve |=> $stable(state));

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
   input  wire core_pkg::decoded_t dec_ex,
   input  wire core_pkg::decoded_t dec_id,
   input  wire                     id_valid,
   bypass_if.hazard                byp,
   output core_pkg::fwd_sel_e      sel_a,
   output core_pkg::fwd_sel_e      sel_b,
   output logic                    load_use_stall
);
   import core_pkg::*;

   // youngest writer wins
   function automatic fwd_sel_e pick(input logic used, input reg_addr_t rs);
      fwd_sel_e sel;
      sel = fwd_rf;
      if (used && rs != '0) begin
         if (byp.ex_valid && byp.ex_writes && !byp.ex_is_load && byp.ex_rd == rs) begin
            sel = fwd_mem;
         end else if (byp.wb_valid && byp.wb_writes && byp.wb_rd == rs) begin
            sel = fwd_wb;
         end
      end
      return sel;
   endfunction

   assign sel_a = pick(dec_ex.uses_rs1, dec_ex.rs1);
   assign sel_b = pick(dec_ex.uses_rs2, dec_ex.rs2);

   ////////////////////
   // load-use
   ////////////////////
   // load data only exists after the memory stage
   assign load_use_stall = id_valid && dec_ex.is_load && dec_ex.rd != '0 &&
                           ((dec_id.uses_rs1 && dec_id.rs1 == dec_ex.rd) ||
                            (dec_id.uses_rs2 && dec_id.rs2 == dec_ex.rd));

   a_no_mem_fwd_from_x0: assert property (@(posedge byp.clk)
      (sel_a == fwd_mem || sel_b == fwd_mem) |-> byp.ex_rd != '0);

   a_no_wb_fwd_from_x0: assert property (@(posedge byp.clk)
      (sel_a == fwd_wb || sel_b == fwd_wb) |-> byp.wb_rd != '0);

endmodule

`default_nettype wire

// ==== verilog/core.sv ====
`default_nettype none
`include "core_params.svh"

module core (
   input  wire                       clk,
   input  wire                       rstn,
   output core_pkg::word_t           rom_addr,
   input  wire core_pkg::word_t      rom_data,
   output logic [`CORE_RAM_AW-1:0]   ram_addr,
   output core_pkg::word_t           ram_wdata,
   output logic                      ram_we,
   input  wire core_pkg::word_t      ram_rdata,
   output logic                      retire_valid,
   output core_pkg::word_t           retire_pc,
   output core_pkg::reg_addr_t       retire_rd,
   output logic                      retire_wen,
   output core_pkg::word_t           retire_data,
   output core_pkg::word_t           retired_count
);
   import core_pkg::*;

   word_t    pc;
   logic     fd_valid;
   word_t    fd_pc;
   word_t    fd_instr;
   decoded_t id_dec;
   word_t    id_rs1_data;
   word_t    id_rs2_data;
   logic     id_predicted;
   logic     redirect_id;
   word_t    redirect_id_pc;
   logic     de_valid;
   decoded_t de_dec;
   word_t    de_rs1_data;
   word_t    de_rs2_data;
   logic     de_predicted;
   decoded_t ex_dec;
   fwd_sel_e sel_a;
   fwd_sel_e sel_b;
   word_t    op_a;
   word_t    op_b;
   word_t    ex_result;
   logic     ex_taken;
   word_t    ex_target;
   logic     load_use_stall;
   logic     mispredict;
   word_t    recover_pc;
   logic     em_valid;
   decoded_t em_dec;
   word_t    em_result;
   word_t    em_store_data;
   logic     mw_valid;
   decoded_t mw_dec;
   word_t    mw_result;
   logic     wb_we;

   bypass_if i_byp (.clk(clk));

   function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t rf_data);
      word_t value;
      case (sel)
         fwd_mem: value = i_byp.mem_result;
         fwd_wb:  value = i_byp.wb_result;
         default: value = rf_data;
      endcase
      return value;
   endfunction

   ////////////////////
   // fetch and decode
   ////////////////////
   assign rom_addr = pc;

   decoder i_decoder (.instr_raw(fd_instr), .pc(fd_pc), .dec(id_dec));

   regfile i_regfile (
      .clk(clk), .rstn(rstn),
      .rs1(id_dec.rs1), .rs2(id_dec.rs2),
      .w_enable(wb_we), .w_addr(mw_dec.rd), .w_data(mw_result),
      .rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
   );

   ////////////////////
   // execute
   ////////////////////
   // bubbles carry no flags
   assign ex_dec = de_valid ? de_dec : '0;
   assign op_a   = fwd_mux(sel_a, de_rs1_data);
   assign op_b   = fwd_mux(sel_b, de_rs2_data);

   alu_exec i_alu_exec (
      .dec(ex_dec), .op_a(op_a), .op_b(op_b),
      .result(ex_result), .taken(ex_taken), .target(ex_target)
   );

   branch_predictor i_branch_predictor (
      .clk(clk), .rstn(rstn),
      .dec_id(id_dec), .id_valid(fd_valid),
      .dec_ex(ex_dec), .ex_valid(de_valid), .ex_taken(ex_taken),
      .ex_target(ex_target), .ex_predicted(de_predicted),
      .redirect_id(redirect_id), .redirect_id_pc(redirect_id_pc),
      .id_predicted(id_predicted),
      .mispredict(mispredict), .recover_pc(recover_pc)
   );

   hazard_unit i_hazard_unit (
      .dec_ex(ex_dec), .dec_id(id_dec), .id_valid(fd_valid), .byp(i_byp),
      .sel_a(sel_a), .sel_b(sel_b), .load_use_stall(load_use_stall)
   );

   assign i_byp.ex_valid   = em_valid;
   assign i_byp.ex_rd      = em_dec.rd;
   assign i_byp.ex_writes  = em_dec.writes_rd;
   assign i_byp.ex_is_load = em_dec.is_load;
   assign i_byp.mem_result = em_result;
   assign i_byp.wb_valid   = mw_valid;
   assign i_byp.wb_rd      = mw_dec.rd;
   assign i_byp.wb_writes  = mw_dec.writes_rd;
   assign i_byp.wb_result  = mw_result;

   ////////////////////
   // memory and write-back
   ////////////////////
   assign ram_addr  = em_result[`CORE_RAM_AW+1:2];
   assign ram_wdata = em_store_data;
   assign ram_we    = em_valid && em_dec.is_store;

   assign wb_we        = mw_valid && mw_dec.writes_rd;
   assign retire_valid = mw_valid;
   assign retire_pc    = mw_dec.pc;
   assign retire_rd    = mw_dec.rd;
   assign retire_wen   = wb_we;
   assign retire_data  = wb_we ? mw_result : '0;

   // valid bits and pc, mispredict > stall > decode redirect > sequential
   always_ff @(posedge clk) begin
      if (rstn) begin
         pc            <= `CORE_RESET_PC;
         fd_valid      <= 1'b0;
         de_valid      <= 1'b0;
         em_valid      <= 1'b0;
         mw_valid      <= 1'b0;
         retired_count <= '0;
      end else begin
         em_valid <= de_valid;
         mw_valid <= em_valid;
         if (mw_valid) begin
            retired_count <= retired_count + 1'b1;
         end
         if (mispredict) begin
            pc       <= recover_pc;
            fd_valid <= 1'b0;
            de_valid <= 1'b0;
         end else if (load_use_stall) begin
            de_valid <= 1'b0;
         end else if (redirect_id) begin
            pc       <= redirect_id_pc;
            fd_valid <= 1'b0;
            de_valid <= fd_valid;
         end else begin
            pc       <= pc + word_t'(`CORE_INSTR_BYTES);
            fd_valid <= 1'b1;
            de_valid <= fd_valid;
         end
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (!load_use_stall) begin
         fd_pc        <= pc;
         fd_instr     <= rom_data;
         de_dec       <= id_dec;
         de_rs1_data  <= id_rs1_data;
         de_rs2_data  <= id_rs2_data;
         de_predicted <= id_predicted;
      end
      em_dec        <= de_dec;
      em_result     <= ex_result;
      em_store_data <= op_b;
      mw_dec        <= em_dec;
      mw_result     <= em_dec.is_load ? ram_rdata : em_result;
   end

   a_pc_aligned: assert property (@(posedge clk) disable iff (rstn) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verif/core_tb.sv ====
`default_nettype none
`include "core_params.svh"

module core_tb;
   import core_pkg::*;

   localparam int CLK_PERIOD      = 4;
   localparam int RESET_CYCLES    = 4;
   localparam int PROG_LEN        = 64;
   localparam int RAM_WORDS       = 1 << `CORE_RAM_AW;
   localparam int WATCHDOG_CYCLES = PROG_LEN * 5 * 4 + RESET_CYCLES;
   localparam word_t NOP_WORD     = 32'h0000_0013;

   // program entry kinds
   localparam int K_OP   = 0;
   localparam int K_ADDI = 1;
   localparam int K_LW   = 2;
   localparam int K_SW   = 3;
   localparam int K_BEQ  = 4;
   localparam int K_BNE  = 5;
   localparam int K_JAL  = 6;

   logic                   clk = 1'b0;
   logic                   rstn;
   word_t                  rom_addr;
   word_t                  rom_data;
   logic [`CORE_RAM_AW-1:0] ram_addr;
   word_t                  ram_wdata;
   logic                   ram_we;
   word_t                  ram_rdata;
   logic                   retire_valid;
   word_t                  retire_pc;
   reg_addr_t              retire_rd;
   logic                   retire_wen;
   word_t                  retire_data;
   word_t                  retired_count;

   word_t     rom [PROG_LEN];
   word_t     ram [RAM_WORDS];
   word_t     model_ram [RAM_WORDS];
   int        prog_kind [PROG_LEN];
   int        prog_op [PROG_LEN];
   reg_addr_t prog_rd [PROG_LEN];
   reg_addr_t prog_rs1 [PROG_LEN];
   reg_addr_t prog_rs2 [PROG_LEN];
   word_t     prog_imm [PROG_LEN];

   // expected retire and store sequences
   word_t     exp_pc [$];
   logic      exp_wen [$];
   reg_addr_t exp_rd [$];
   word_t     exp_data [$];
   word_t     st_addr [$];
   word_t     st_data [$];
   word_t     last_pc;
   logic      last_wen;
   reg_addr_t last_rd;
   word_t     last_data;

   logic [15:0] lfsr_state;
   int          err_retire = 0;
   int          err_store  = 0;
   int          err_count  = 0;
   int          err_other  = 0;
   int          seen       = 0;
   int          edges      = 0;
   int          run_edges  = 0;
   logic        finished   = 1'b0;

   core i_core (
      .clk(clk), .rstn(rstn),
      .rom_addr(rom_addr), .rom_data(rom_data),
      .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we), .ram_rdata(ram_rdata),
      .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
      .retire_wen(retire_wen), .retire_data(retire_data), .retired_count(retired_count)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////
   // memories
   ////////////////////
   assign rom_data  = (rom_addr < PROG_LEN * 4) ? rom[rom_addr[7:2]] : NOP_WORD;
   assign ram_rdata = ram[ram_addr];

   always @(posedge clk) begin
      if (ram_we === 1'b1) begin
         ram[ram_addr] <= ram_wdata;
      end
   end

   function automatic word_t fill_word(input int unsigned a);
      return 32'h5a5a_0000 ^ (a * 32'h0001_0193) ^ (a << 20);
   endfunction

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         bits = {bits[30:0], lfsr_state[0]};
      end
   endtask

   function automatic word_t encode(input int i);
      word_t      imm;
      logic [6:0] f7;
      logic [2:0] f3;
      imm = prog_imm[i];
      f7  = 7'h00;
      case (prog_op[i])
         0: f3 = 3'b000;
         1: begin
            f7 = 7'h20;
            f3 = 3'b000;
         end
         2: f3 = 3'b111;
         3: f3 = 3'b110;
         4: f3 = 3'b100;
         default: f3 = 3'b010;
      endcase
      case (prog_kind[i])
         K_OP:   return {f7, prog_rs2[i], prog_rs1[i], f3, prog_rd[i], 7'b0110011};
         K_ADDI: return {imm[11:0], prog_rs1[i], 3'b000, prog_rd[i], 7'b0010011};
         K_LW:   return {imm[11:0], prog_rs1[i], 3'b010, prog_rd[i], 7'b0000011};
         K_SW:   return {imm[11:5], prog_rs2[i], prog_rs1[i], 3'b010, imm[4:0], 7'b0100011};
         K_BEQ, K_BNE: return {imm[12], imm[10:5], prog_rs2[i], prog_rs1[i],
                               (prog_kind[i] == K_BNE) ? 3'b001 : 3'b000,
                               imm[4:1], imm[11], 7'b1100011};
         default: return {imm[20], imm[10:1], imm[11], imm[19:12], prog_rd[i], 7'b1101111};
      endcase
   endfunction

   ////////////////////
   // program generator
   ////////////////////
   task automatic build_program();
      logic [31:0] r;
      int          k;
      for (int i = 0; i < PROG_LEN; i++) begin
         prog_op[i]  = 0;
         prog_rd[i]  = '0;
         prog_rs1[i] = '0;
         prog_rs2[i] = '0;
         prog_imm[i] = '0;
         if (i == 0) begin
            // x1 is the load/store base, never rewritten
            prog_kind[i] = K_ADDI;
            prog_rd[i]   = reg_addr_t'(1);
            prog_imm[i]  = 32'd64;
         end else if (i < 8) begin
            prog_kind[i] = K_ADDI;
            prog_rd[i]   = (i == 1) ? reg_addr_t'(0) : reg_addr_t'(i);
            take_bits(12, r);
            prog_imm[i] = {{20{r[11]}}, r[11:0]};
         end else if (i == PROG_LEN - 1) begin
            prog_kind[i] = K_JAL;
         end else begin
            take_bits(3, r);
            prog_kind[i] = (r < 2) ? K_OP : int'(r) - 1;
            take_bits(3, r);
            prog_rd[i] = (r == 1) ? reg_addr_t'(0) : reg_addr_t'(r);
            take_bits(3, r);
            prog_rs1[i] = reg_addr_t'(r);
            take_bits(3, r);
            prog_rs2[i] = reg_addr_t'(r);
            case (prog_kind[i])
               K_OP: begin
                  take_bits(3, r);
                  prog_op[i] = int'(r) % 6;
               end
               K_ADDI: begin
                  take_bits(12, r);
                  prog_imm[i] = {{20{r[11]}}, r[11:0]};
               end
               K_LW, K_SW: begin
                  prog_rs1[i] = reg_addr_t'(1);
                  take_bits(3, r);
                  prog_imm[i] = r * 4;
               end
               default: begin
                  if (prog_kind[i] != K_JAL) begin
                     take_bits(1, r);
                     if (r[0]) prog_rs2[i] = prog_rs1[i];
                  end
                  // forward only
                  take_bits(2, r);
                  k = int'(r) + 1;
                  if (i + k > PROG_LEN - 1) k = PROG_LEN - 1 - i;
                  prog_imm[i] = word_t'(k * 4);
               end
            endcase
            if (prog_kind[i] == K_SW || prog_kind[i] == K_BEQ || prog_kind[i] == K_BNE) begin
               prog_rd[i] = '0;
            end
         end
         rom[i] = encode(i);
      end
   endtask

   // in-order instruction-set model
   task automatic run_model();
      word_t regs [8];
      word_t pc;
      word_t a;
      word_t b;
      word_t res;
      word_t addr;
      word_t next_pc;
      logic  wen;
      int    i;
      logic  stop;
      for (int r = 0; r < 8; r++) regs[r] = '0;
      pc   = `CORE_RESET_PC;
      stop = 1'b0;
      while (!stop) begin
         i       = int'(pc >> 2);
         a       = regs[prog_rs1[i]];
         b       = regs[prog_rs2[i]];
         res     = '0;
         wen     = 1'b0;
         addr    = a + prog_imm[i];
         next_pc = pc + 4;
         case (prog_kind[i])
            K_OP: begin
               wen = 1'b1;
               case (prog_op[i])
                  0: res = a + b;
                  1: res = a - b;
                  2: res = a & b;
                  3: res = a | b;
                  4: res = a ^ b;
                  default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               endcase
            end
            K_ADDI: begin
               wen = 1'b1;
               res = a + prog_imm[i];
            end
            K_LW: begin
               wen = 1'b1;
               res = model_ram[addr[11:2]];
            end
            K_SW: begin
               model_ram[addr[11:2]] = b;
               st_addr.push_back(word_t'(addr[11:2]));
               st_data.push_back(b);
            end
            K_BEQ: if (a == b) next_pc = pc + prog_imm[i];
            K_BNE: if (a != b) next_pc = pc + prog_imm[i];
            default: begin
               wen     = 1'b1;
               res     = pc + 4;
               next_pc = pc + prog_imm[i];
            end
         endcase
         if (prog_rd[i] == '0) wen = 1'b0;
         if (wen) regs[prog_rd[i]] = res;
         else res = '0;
         exp_pc.push_back(pc);
         exp_wen.push_back(wen);
         exp_rd.push_back(prog_rd[i]);
         exp_data.push_back(res);
         stop = (i == PROG_LEN - 1);
         pc   = next_pc;
      end
   endtask

   ////////////////////
   // checks
   ////////////////////
   task automatic check_retire(input word_t pc, input logic wen, input reg_addr_t rd,
                               input word_t data);
      if (retire_pc !== pc) begin
         err_retire++;
         $display("ERROR %0t: retire pc %h, expected %h", $time, retire_pc, pc);
      end else if (retire_wen !== wen) begin
         err_retire++;
         $display("ERROR %0t: pc %h retire_wen %b, expected %b", $time, pc, retire_wen, wen);
      end else if (wen && (retire_rd !== rd || retire_data !== data)) begin
         err_retire++;
         $display("ERROR %0t: pc %h wrote x%0d=%h, expected x%0d=%h", $time, pc,
                  retire_rd, retire_data, rd, data);
      end
      if (retire_rd == '0 && (retire_wen !== 1'b0 || retire_data !== '0)) begin
         err_retire++;
         $display("ERROR %0t: x0 reported as written with %h", $time, retire_data);
      end
   endtask

   task automatic check_store(input word_t addr, input word_t data);
      if (word_t'(ram_addr) !== addr || ram_wdata !== data) begin
         err_store++;
         $display("ERROR %0t: store word %0d data %h, expected word %0d data %h", $time,
                  ram_addr, ram_wdata, addr, data);
      end
   endtask

   task automatic check_count(input word_t expected);
      if (retired_count !== expected) begin
         err_count++;
         $display("ERROR %0t: retired_count %0d, expected %0d", $time, retired_count, expected);
      end
   endtask

   always @(posedge clk) begin
      edges <= edges + 1;
      if (!rstn) run_edges <= run_edges + 1;
   end

   // sample on the falling edge, outputs settle after the rising edge
   always @(negedge clk) begin
      if (edges > 0) begin
         if (run_edges < 4 && retire_valid !== 1'b0) begin
            err_other++;
            $display("ERROR %0t: retire_valid high before any instruction could retire", $time);
         end
         if (run_edges < 3 && ram_we !== 1'b0) begin
            err_other++;
            $display("ERROR %0t: ram_we high before any store could reach memory", $time);
         end
         check_count(word_t'(seen));
         if (retire_valid === 1'b1) begin
            if (exp_pc.size() > 0) begin
               last_pc   = exp_pc.pop_front();
               last_wen  = exp_wen.pop_front();
               last_rd   = exp_rd.pop_front();
               last_data = exp_data.pop_front();
               if (exp_pc.size() == 0) finished = 1'b1;
            end
            // after the end only the final self-loop retires
            check_retire(last_pc, last_wen, last_rd, last_data);
            seen++;
         end
         if (ram_we === 1'b1) begin
            if (st_addr.size() == 0) begin
               err_other++;
               $display("ERROR %0t: RAM write at word %0d that the program never makes",
                        $time, ram_addr);
            end else begin
               check_store(st_addr.pop_front(), st_data.pop_front());
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("ERROR %0t: watchdog expired, the program did not reach its last jump", $time);
      $display("Checks failed");
      $finish;
   end

   initial begin
      rstn       = 1'b1;
      lfsr_state = 16'd15;
      for (int a = 0; a < RAM_WORDS; a++) begin
         ram[a]       = fill_word(a);
         model_ram[a] = fill_word(a);
      end
      build_program();
      run_model();
      repeat (RESET_CYCLES) @(negedge clk);
      rstn = 1'b0;
      wait (finished);
      repeat (8) @(negedge clk);
      if (st_addr.size() != 0) begin
         err_other++;
         $display("ERROR %0t: %0d stores of the program never reached RAM", $time,
                  st_addr.size());
      end
      $display("errors: retire %0d, store %0d, count %0d, other %0d",
               err_retire, err_store, err_count, err_other);
      if (err_retire + err_store + err_count + err_other == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/bypass_if.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu_exec.sv
verilog/branch_predictor.sv
verilog/hazard_unit.sv
verilog/core.sv
verif/core_tb.sv
